//--- verilog/risc_pkg.sv
package risc_pkg;

	localparam int word_w    = 16;
	localparam int reg_w     = 3;
	localparam int op_w      = 4;
	localparam int cz_w      = 2;
	localparam int op_full_w = op_w + cz_w;      // opcode plus cz
	localparam int imm6_w    = 6;
	localparam int imm9_w    = 9;
	localparam int fwd_w     = 2;

	// register-type operations carry opcode and cz together
	localparam logic [op_full_w-1:0] op_add = 6'b000000;
	localparam logic [op_full_w-1:0] op_adc = 6'b000010;   // runs if carry set
	localparam logic [op_full_w-1:0] op_adz = 6'b000001;   // runs if zero set
	localparam logic [op_full_w-1:0] op_ndu = 6'b001000;
	localparam logic [op_full_w-1:0] op_ndc = 6'b001010;
	localparam logic [op_full_w-1:0] op_ndz = 6'b001001;

	// immediate forms use the opcode only
	localparam logic [op_w-1:0] op_adi = 4'b0001;
	localparam logic [op_w-1:0] op_lhi = 4'b0011;

	// operand and flag sources
	localparam logic [fwd_w-1:0] fwd_none   = 2'd0;      // value read at decode
	localparam logic [fwd_w-1:0] fwd_ex_mem = 2'd1;
	localparam logic [fwd_w-1:0] fwd_mem_wb = 2'd2;

	typedef union packed {
		struct packed {
			logic [op_w-1:0]  opcode;
			logic [reg_w-1:0] ra;
			logic [reg_w-1:0] rb;
			logic [reg_w-1:0] rc;
			logic             spare;
			logic [cz_w-1:0]  cz;
		} r_fmt;
		struct packed {
			logic [op_w-1:0]   opcode;
			logic [reg_w-1:0]  ra;
			logic [reg_w-1:0]  rb;
			logic [imm6_w-1:0] imm;    // signed
		} i_fmt;
		struct packed {
			logic [op_w-1:0]   opcode;
			logic [reg_w-1:0]  ra;
			logic [imm9_w-1:0] imm;
		} j_fmt;
	} instr_t;

endpackage

//--- verilog/reg_file.sv
module reg_file
	import risc_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [reg_w-1:0]  ra_addr,
	input  logic [reg_w-1:0]  rb_addr,
	output logic [word_w-1:0] ra_data,
	output logic [word_w-1:0] rb_data,
	input  logic              we,
	input  logic [reg_w-1:0]  wr_addr,
	input  logic [word_w-1:0] wr_data
);

	logic [word_w-1:0] regs [0:(1<<reg_w)-1];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < (1 << reg_w); i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-first so decode sees a same-cycle write
	assign ra_data = (we && wr_addr == ra_addr) ? wr_data : regs[ra_addr];
	assign rb_data = (we && wr_addr == rb_addr) ? wr_data : regs[rb_addr];

endmodule

//--- verilog/decode_read_stage.sv
module decode_read_stage
	import risc_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  instr_t               instr,
	input  logic [word_w-1:0]    ra_data,
	input  logic [word_w-1:0]    rb_data,
	output logic [reg_w-1:0]     ra_addr,
	output logic [reg_w-1:0]     rb_addr,
	output logic                 id_valid,
	output logic [op_full_w-1:0] id_op,
	output logic [reg_w-1:0]     id_ra,
	output logic [reg_w-1:0]     id_rb,
	output logic [reg_w-1:0]     id_rc,
	output logic [reg_w-1:0]     id_rd,
	output logic [word_w-1:0]    id_a,
	output logic [word_w-1:0]    id_b,
	output logic [word_w-1:0]    id_imm
);

	logic [op_w-1:0]   opcode;
	logic [reg_w-1:0]  rd;
	logic [word_w-1:0] imm;

	assign opcode  = instr.r_fmt.opcode;
	assign ra_addr = instr.r_fmt.ra;
	assign rb_addr = instr.r_fmt.rb;

	always_comb
	begin
		rd  = instr.r_fmt.rc;          // register type writes rc
		imm = '0;
		if (opcode == op_adi)
		begin
			rd  = instr.i_fmt.rb;
			imm = {{(word_w-imm6_w){instr.i_fmt.imm[imm6_w-1]}}, instr.i_fmt.imm};
		end
		else if (opcode == op_lhi)
		begin
			rd  = instr.j_fmt.ra;
			imm = {instr.j_fmt.imm, {(word_w-imm9_w){1'b0}}};   // into upper 9 bits
		end
	end

	// regread_ex stage register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			id_valid <= 1'b0;
			id_op    <= '0;
			id_ra    <= '0;
			id_rb    <= '0;
			id_rc    <= '0;
			id_rd    <= '0;
		end
		else
		begin
			id_valid <= instr_valid;       // bubble when low
			id_op    <= {opcode, instr.r_fmt.cz};
			id_ra    <= instr.r_fmt.ra;
			id_rb    <= instr.r_fmt.rb;
			id_rc    <= instr.r_fmt.rc;
			id_rd    <= rd;
		end
	end

	always_ff @(posedge clk)
	begin
		id_a   <= ra_data;
		id_b   <= rb_data;
		id_imm <= imm;
	end

endmodule

//--- verilog/forward_ex_stage.sv
module forward_ex_stage
	import risc_pkg::*;
(
	input  logic [op_full_w-1:0] id_op,
	input  logic [reg_w-1:0]     id_ra,
	input  logic [reg_w-1:0]     id_rb,
	input  logic                 ex_mem_valid,
	input  logic [reg_w-1:0]     ex_mem_rd,
	input  logic                 ex_mem_we,
	input  logic                 ex_mem_c_we,
	input  logic                 ex_mem_z_we,
	input  logic                 mem_wb_valid,
	input  logic [reg_w-1:0]     mem_wb_rd,
	input  logic                 mem_wb_we,
	input  logic                 mem_wb_c_we,
	input  logic                 mem_wb_z_we,
	output logic [fwd_w-1:0]     f1,
	output logic [fwd_w-1:0]     f2,
	output logic [fwd_w-1:0]     fc,
	output logic [fwd_w-1:0]     fz
);

	logic is_rr;
	logic is_adi;
	logic is_cond;
	logic ex_wr;
	logic wb_wr;

	// younger stage wins
	function automatic logic [fwd_w-1:0] pick_src(input logic ex_hit, input logic wb_hit);
		if (ex_hit)
			return fwd_ex_mem;
		else if (wb_hit)
			return fwd_mem_wb;
		return fwd_none;
	endfunction

	assign is_cond = (id_op == op_adc) || (id_op == op_adz) ||
	                 (id_op == op_ndc) || (id_op == op_ndz);
	assign is_rr   = is_cond || (id_op == op_add) || (id_op == op_ndu);
	assign is_adi  = (id_op[op_full_w-1 -: op_w] == op_adi);

	assign ex_wr = ex_mem_valid && ex_mem_we;
	assign wb_wr = mem_wb_valid && mem_wb_we;

	always_comb
	begin
		f1 = fwd_none;
		f2 = fwd_none;
		fc = fwd_none;
		fz = fwd_none;

		if (is_rr || is_adi)
			f1 = pick_src(ex_wr && ex_mem_rd == id_ra, wb_wr && mem_wb_rd == id_ra);

		if (is_rr)                     // adi has no second register operand
			f2 = pick_src(ex_wr && ex_mem_rd == id_rb, wb_wr && mem_wb_rd == id_rb);

		// a skipped older op leaves its flags alone, so c_we and z_we decide
		if (is_cond)
		begin
			fc = pick_src(ex_mem_valid && ex_mem_c_we, mem_wb_valid && mem_wb_c_we);
			fz = pick_src(ex_mem_valid && ex_mem_z_we, mem_wb_valid && mem_wb_z_we);
		end
	end

endmodule

//--- verilog/execute_stage.sv
module execute_stage
	import risc_pkg::*;
(
	input  logic                 id_valid,
	input  logic [op_full_w-1:0] id_op,
	input  logic [reg_w-1:0]     id_rd,
	input  logic [word_w-1:0]    id_a,
	input  logic [word_w-1:0]    id_b,
	input  logic [word_w-1:0]    id_imm,
	input  logic [fwd_w-1:0]     f1,
	input  logic [fwd_w-1:0]     f2,
	input  logic [fwd_w-1:0]     fc,
	input  logic [fwd_w-1:0]     fz,
	input  logic [word_w-1:0]    ex_mem_result,
	input  logic                 ex_mem_c,
	input  logic                 ex_mem_z,
	input  logic [word_w-1:0]    mem_wb_result,
	input  logic                 mem_wb_c,
	input  logic                 mem_wb_z,
	input  logic                 flag_c,
	input  logic                 flag_z,
	output logic                 ex_valid,
	output logic [reg_w-1:0]     ex_rd,
	output logic                 ex_we,
	output logic                 ex_c_we,
	output logic                 ex_z_we,
	output logic [word_w-1:0]    ex_result,
	output logic                 ex_c,
	output logic                 ex_z
);

	logic [word_w-1:0] opa;
	logic [word_w-1:0] opb;
	logic              cond_c;
	logic              cond_z;
	logic [word_w:0]   sum;            // carry out on top
	logic              is_adi;
	logic              is_lhi;
	logic              supported;
	logic              run;
	logic              do_c_we;
	logic              do_z_we;
	logic              go;

	always_comb
	begin
		case (f1)
			fwd_ex_mem: opa = ex_mem_result;
			fwd_mem_wb: opa = mem_wb_result;
			default:    opa = id_a;
		endcase
		case (f2)
			fwd_ex_mem: opb = ex_mem_result;
			fwd_mem_wb: opb = mem_wb_result;
			default:    opb = id_b;
		endcase
		case (fc)
			fwd_ex_mem: cond_c = ex_mem_c;
			fwd_mem_wb: cond_c = mem_wb_c;
			default:    cond_c = flag_c;
		endcase
		case (fz)
			fwd_ex_mem: cond_z = ex_mem_z;
			fwd_mem_wb: cond_z = mem_wb_z;
			default:    cond_z = flag_z;
		endcase
	end

	assign is_adi = (id_op[op_full_w-1 -: op_w] == op_adi);
	assign is_lhi = (id_op[op_full_w-1 -: op_w] == op_lhi);
	assign sum    = {1'b0, opa} + {1'b0, (is_adi ? id_imm : opb)};

	always_comb
	begin
		supported = 1'b1;
		run       = 1'b1;
		do_c_we   = 1'b0;
		do_z_we   = 1'b0;
		ex_result = sum[word_w-1:0];
		if (is_adi)
		begin
			do_c_we = 1'b1;
			do_z_we = 1'b1;
		end
		else if (is_lhi)
		begin
			ex_result = id_imm;        // no flags
		end
		else
		begin
			case (id_op)
				op_add, op_adc, op_adz:
				begin
					do_c_we = 1'b1;
					do_z_we = 1'b1;
				end
				op_ndu, op_ndc, op_ndz:
				begin
					ex_result = ~(opa & opb);
					do_z_we   = 1'b1;  // carry untouched by nand
				end
				default: supported = 1'b0;
			endcase
			if (id_op == op_adc || id_op == op_ndc)
				run = cond_c;
			if (id_op == op_adz || id_op == op_ndz)
				run = cond_z;
		end
	end

	assign go       = id_valid && supported && run;
	assign ex_valid = id_valid;
	assign ex_rd    = id_rd;
	assign ex_we    = go;
	assign ex_c_we  = go && do_c_we;
	assign ex_z_we  = go && do_z_we;
	assign ex_c     = sum[word_w];
	assign ex_z     = (ex_result == '0);

endmodule

//--- verilog/result_pipe.sv
module result_pipe
	import risc_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ex_valid,
	input  logic [reg_w-1:0]  ex_rd,
	input  logic              ex_we,
	input  logic              ex_c_we,
	input  logic              ex_z_we,
	input  logic [word_w-1:0] ex_result,
	input  logic              ex_c,
	input  logic              ex_z,
	output logic              ex_mem_valid,
	output logic [reg_w-1:0]  ex_mem_rd,
	output logic              ex_mem_we,
	output logic              ex_mem_c_we,
	output logic              ex_mem_z_we,
	output logic [word_w-1:0] ex_mem_result,
	output logic              ex_mem_c,
	output logic              ex_mem_z,
	output logic              mem_wb_valid,
	output logic [reg_w-1:0]  mem_wb_rd,
	output logic              mem_wb_we,
	output logic              mem_wb_c_we,
	output logic              mem_wb_z_we,
	output logic [word_w-1:0] mem_wb_result,
	output logic              mem_wb_c,
	output logic              mem_wb_z,
	output logic              flag_c,
	output logic              flag_z,
	output logic              wb_valid,
	output logic              wb_we,
	output logic [reg_w-1:0]  wb_rd,
	output logic [word_w-1:0] wb_data
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ex_mem_valid <= 1'b0;
			ex_mem_rd    <= '0;
			ex_mem_we    <= 1'b0;
			ex_mem_c_we  <= 1'b0;
			ex_mem_z_we  <= 1'b0;
			mem_wb_valid <= 1'b0;
			mem_wb_rd    <= '0;
			mem_wb_we    <= 1'b0;
			mem_wb_c_we  <= 1'b0;
			mem_wb_z_we  <= 1'b0;
			flag_c       <= 1'b0;
			flag_z       <= 1'b0;
		end
		else
		begin
			ex_mem_valid <= ex_valid;
			ex_mem_rd    <= ex_rd;
			ex_mem_we    <= ex_we;
			ex_mem_c_we  <= ex_c_we;
			ex_mem_z_we  <= ex_z_we;
			mem_wb_valid <= ex_mem_valid;
			mem_wb_rd    <= ex_mem_rd;
			mem_wb_we    <= ex_mem_we;
			mem_wb_c_we  <= ex_mem_c_we;
			mem_wb_z_we  <= ex_mem_z_we;
			if (mem_wb_c_we)
				flag_c <= mem_wb_c;    // same edge as the register write
			if (mem_wb_z_we)
				flag_z <= mem_wb_z;
		end
	end

	// result payload
	always_ff @(posedge clk)
	begin
		ex_mem_result <= ex_result;
		ex_mem_c      <= ex_c;
		ex_mem_z      <= ex_z;
		mem_wb_result <= ex_mem_result;
		mem_wb_c      <= ex_mem_c;
		mem_wb_z      <= ex_mem_z;
	end

	assign wb_valid = mem_wb_valid;
	assign wb_we    = mem_wb_we;
	assign wb_rd    = mem_wb_rd;
	assign wb_data  = mem_wb_result;

endmodule

//--- verilog/pipe_top.sv
module pipe_top
	import risc_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  instr_t            instr,
	output logic              wb_valid,
	output logic              wb_we,
	output logic [reg_w-1:0]  wb_rd,
	output logic [word_w-1:0] wb_data,
	output logic              flag_c,
	output logic              flag_z
);

	// register file read side
	logic [reg_w-1:0]     ra_addr;
	logic [reg_w-1:0]     rb_addr;
	logic [word_w-1:0]    ra_data;
	logic [word_w-1:0]    rb_data;

	// regread_ex
	logic                 id_valid;
	logic [op_full_w-1:0] id_op;
	logic [reg_w-1:0]     id_ra;
	logic [reg_w-1:0]     id_rb;
	logic [reg_w-1:0]     id_rc;
	logic [reg_w-1:0]     id_rd;
	logic [word_w-1:0]    id_a;
	logic [word_w-1:0]    id_b;
	logic [word_w-1:0]    id_imm;

	logic [fwd_w-1:0]     f1;
	logic [fwd_w-1:0]     f2;
	logic [fwd_w-1:0]     fc;
	logic [fwd_w-1:0]     fz;

	// execute results
	logic                 ex_valid;
	logic [reg_w-1:0]     ex_rd;
	logic                 ex_we;
	logic                 ex_c_we;
	logic                 ex_z_we;
	logic [word_w-1:0]    ex_result;
	logic                 ex_c;
	logic                 ex_z;

	// ex_mem and mem_wb
	logic                 ex_mem_valid;
	logic [reg_w-1:0]     ex_mem_rd;
	logic                 ex_mem_we;
	logic                 ex_mem_c_we;
	logic                 ex_mem_z_we;
	logic [word_w-1:0]    ex_mem_result;
	logic                 ex_mem_c;
	logic                 ex_mem_z;
	logic                 mem_wb_valid;
	logic [reg_w-1:0]     mem_wb_rd;
	logic                 mem_wb_we;
	logic                 mem_wb_c_we;
	logic                 mem_wb_z_we;
	logic [word_w-1:0]    mem_wb_result;
	logic                 mem_wb_c;
	logic                 mem_wb_z;

	reg_file rf_i (
		.*,
		.we      (wb_we),
		.wr_addr (wb_rd),
		.wr_data (wb_data)
	);

	decode_read_stage id_i (.*);

	forward_ex_stage fwd_i (.*);

	execute_stage ex_i (.*);

	result_pipe rp_i (.*);

endmodule

//--- verification/tb_clock.sv
module tb_clock
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;             // period 10
	end

endmodule

//--- verification/pipe_props.sv
module pipe_props
	import risc_pkg::*;
(
	input logic              clk,
	input logic              rst_n,
	input logic [fwd_w-1:0]  f1,
	input logic [fwd_w-1:0]  f2,
	input logic [fwd_w-1:0]  fc,
	input logic [fwd_w-1:0]  fz,
	input logic              wb_valid,
	input logic              wb_we,
	input logic              ex_mem_valid,
	input logic [word_w-1:0] ex_mem_result,
	input logic              mem_wb_valid,
	input logic [word_w-1:0] mem_wb_result
);

	a_operand_sel: assert property (@(posedge clk) disable iff (!rst_n)
		f1 != 2'd3 && f2 != 2'd3)
		else $error("operand forward select holds an undefined code");

	a_flag_sel: assert property (@(posedge clk) disable iff (!rst_n)
		fc != 2'd3 && fz != 2'd3)
		else $error("flag forward select holds an undefined code");

	a_we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wb_we |-> wb_valid)
		else $error("register write without a valid writeback");

	// ex_mem moves into mem_wb unchanged
	a_result_moves: assert property (@(posedge clk) disable iff (!rst_n)
		ex_mem_valid |=> mem_wb_valid && mem_wb_result == $past(ex_mem_result))
		else $error("ex_mem result did not reach mem_wb one cycle later");

endmodule

bind pipe_top pipe_props props_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.f1            (f1),
	.f2            (f2),
	.fc            (fc),
	.fz            (fz),
	.wb_valid      (wb_valid),
	.wb_we         (wb_we),
	.ex_mem_valid  (ex_mem_valid),
	.ex_mem_result (ex_mem_result),
	.mem_wb_valid  (mem_wb_valid),
	.mem_wb_result (mem_wb_result)
);

//--- verification/tb_top.sv
module tb_top
	import risc_pkg::*;
();

	localparam int n_slots       = 400;
	localparam int max_edges     = 2 + n_slots + 3 + 20;
	localparam int first_wb_edge = 5;          // slot 0 sampled at edge 3
	localparam logic [31:0] lfsr_mask = 32'h8020_0003;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	instr_t            instr;
	logic              wb_valid;
	logic              wb_we;
	logic [reg_w-1:0]  wb_rd;
	logic [word_w-1:0] wb_data;
	logic              flag_c;
	logic              flag_z;

	logic [31:0]       lfsr;
	int                edge_cnt = 0;
	int                checked = 0;
	logic              flag_pending = 1'b0;
	logic [1:0]        pending_flags;          // c, z
	logic [22:0]       exp_q [$];              // valid, we, rd, data, c, z
	logic [word_w-1:0] m_regs [0:7];
	logic              m_c;
	logic              m_z;

	tb_clock clk_i (.clk(clk));

	pipe_top dut_i (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ lfsr_mask;
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// mostly r0 to r3 so hazards stay frequent
	function automatic logic [reg_w-1:0] pick_reg();
		logic [31:0] b;
		b = (take_bits(2) != 0) ? take_bits(2) : take_bits(3);
		return b[reg_w-1:0];
	endfunction

	function automatic logic [word_w-1:0] make_instr();
		logic [31:0]          sel;
		logic [31:0]          imm;
		logic [reg_w-1:0]     ra;
		logic [reg_w-1:0]     rb;
		logic [reg_w-1:0]     rc;
		logic [op_full_w-1:0] full;
		sel = take_bits(4);
		imm = take_bits(12);
		ra  = pick_reg();
		rb  = pick_reg();
		rc  = pick_reg();
		case (sel[3:0])
			4'd0, 4'd1:   full = op_add;
			4'd2, 4'd3:   full = op_adc;
			4'd4, 4'd5:   full = op_adz;
			4'd6, 4'd7:   full = op_ndu;
			4'd8:         full = op_ndc;
			4'd9:         full = op_ndz;
			4'd10, 4'd11: return {op_adi, ra, rb, imm[5:0]};
			4'd12, 4'd13: return {op_lhi, ra, imm[8:0]};
			4'd14:        full = {1'b1, imm[11:9], 2'b00};   // unsupported opcode 1xxx
			default:      full = {op_add[5:2], 2'b11};       // add with cz 11 is unsupported
		endcase
		return {full[5:2], ra, rb, rc, imm[0], full[1:0]};
	endfunction

	// in-order reference model called once per slot
	task automatic model_exec(input logic valid, input logic [word_w-1:0] w);
		logic [op_full_w-1:0] full;
		logic [reg_w-1:0]     rd;
		logic [word_w-1:0]    a;
		logic [word_w-1:0]    res;
		logic [word_w:0]      sum;
		logic                 we;
		logic                 wc;
		logic                 wz;
		logic                 run;
		full = {w[15:12], w[1:0]};
		a    = m_regs[w[11:9]];
		sum  = {1'b0, a} + {1'b0, m_regs[w[8:6]]};
		rd   = w[5:3];
		res  = sum[word_w-1:0];
		{we, wc, wz} = 3'b000;
		run  = 1'b1;
		if (w[15:12] == op_adi)
		begin
			rd  = w[8:6];
			sum = {1'b0, a} + {1'b0, {10{w[5]}}, w[5:0]};
			res = sum[word_w-1:0];
			{we, wc, wz} = 3'b111;
		end
		else if (w[15:12] == op_lhi)
		begin
			rd  = w[11:9];
			res = {w[8:0], 7'b0};
			we  = 1'b1;                    // flags untouched
		end
		else if (full == op_add || full == op_adc || full == op_adz)
			{we, wc, wz} = 3'b111;
		else if (full == op_ndu || full == op_ndc || full == op_ndz)
		begin
			res = ~(a & m_regs[w[8:6]]);
			{we, wc, wz} = 3'b101;         // nand keeps carry
		end
		if (full == op_adc || full == op_ndc)
			run = m_c;
		if (full == op_adz || full == op_ndz)
			run = m_z;
		we = valid && we && run;
		if (we)
			m_regs[rd] = res;
		if (we && wc)
			m_c = sum[word_w];
		if (we && wz)
			m_z = (res == '0);
		exp_q.push_back({valid, we, rd, res, m_c, m_z});
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	initial
	begin
		logic [word_w-1:0] w;
		logic              v;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		lfsr        = 32'hd9b9_79c7;
		m_c         = 1'b0;
		m_z         = 1'b0;
		for (int r = 0; r < 8; r++)
			m_regs[r] = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_slots; i++)
		begin
			v = (take_bits(3) != 0);       // about 1 in 8 is a bubble
			w = make_instr();
			model_exec(v, w);
			instr_valid <= v;
			instr       <= w;
			@(posedge clk);
		end
		instr_valid <= 1'b0;
		instr       <= '0;
		wait (checked == n_slots && !flag_pending);
		$display("sim passed");
		$finish;
	end

	// wb outputs are stable at the falling edge
	always @(negedge clk)
	begin
		logic [22:0] e;
		if (flag_pending)
		begin
			check_value($sformatf("slot %0d flag_c", checked - 1),
			            32'(pending_flags[1]), 32'(flag_c));
			check_value($sformatf("slot %0d flag_z", checked - 1),
			            32'(pending_flags[0]), 32'(flag_z));
			flag_pending = 1'b0;
		end
		if (edge_cnt >= first_wb_edge && checked < n_slots)
		begin
			e = exp_q.pop_front();
			check_value($sformatf("slot %0d wb_valid", checked), 32'(e[22]), 32'(wb_valid));
			if (e[22])
				check_value($sformatf("slot %0d wb_we", checked), 32'(e[21]), 32'(wb_we));
			if (e[21])
			begin
				check_value($sformatf("slot %0d wb_rd", checked), 32'(e[20:18]), 32'(wb_rd));
				check_value($sformatf("slot %0d wb_data", checked), 32'(e[17:2]), 32'(wb_data));
			end
			pending_flags = e[1:0];        // flags settle one edge later
			flag_pending  = 1'b1;
			checked++;
		end
		else if (edge_cnt != 0)            // nothing clocked yet at time zero
			check_value("idle wb_valid", 32'd0, 32'(wb_valid));
	end

	always @(posedge clk)
	begin
		edge_cnt <= edge_cnt + 1;
		if (edge_cnt >= max_edges)
		begin
			$display("writebacks missing, %0d of %0d seen at the cycle limit", checked, n_slots);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

endmodule

//--- src.f
verilog/risc_pkg.sv
verilog/reg_file.sv
verilog/decode_read_stage.sv
verilog/forward_ex_stage.sv
verilog/execute_stage.sv
verilog/result_pipe.sv
verilog/pipe_top.sv
verification/tb_clock.sv
verification/pipe_props.sv
verification/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f src.f -o tb_top_sim

status=0
./obj_dir/tb_top_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log || [ "$status" -ne 0 ]; then
	echo "run failed, see sim.log"
	exit 1
fi
echo "run passed"
